// ==== design/lockstep_pkg.sv ====
package lockstep_pkg;

    // --------------------------------------------------
    // Widths with a meaning
    // --------------------------------------------------

    // Only the low ADDR_W bits reach the memory
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;
    typedef logic [1:0]  module_id_t;

    // --------------------------------------------------
    // Broadcast bus
    // --------------------------------------------------

    typedef enum logic [1:0]
    {
        BEAT_IDLE  = 2'd0,
        BEAT_SCAN  = 2'd1,
        BEAT_WRITE = 2'd2
    } beat_e;

    typedef struct packed
    {
        logic  ok;
        beat_e beat;
        addr_t addr;
        data_t data;
        logic  sync;
    } bcast_t;

    // --------------------------------------------------
    // Rebuild sequence
    // --------------------------------------------------

    typedef enum logic [1:0]
    {
        RL_REBUILD = 2'd0,
        RL_ALIGN   = 2'd1,
        RL_REJOIN  = 2'd2,
        RL_RUN     = 2'd3
    } run_level_e;

    // Cycles from the neighbor sync to rejoining
    localparam int SYNC_DELAY = 3;

    // Full scan wraps seen before aligning
    localparam int REBUILD_PASSES = 2;

endpackage

// ==== design/state_ram.sv ====
`timescale 1ns/1ps

module state_ram
    import lockstep_pkg::*;
#(
    parameter int ADDR_W = 9
)
(
    input  logic  CORE_CLK,
    // Scanner side
    input  logic  a_we,
    input  addr_t a_addr,
    input  data_t a_wdata,
    output data_t a_rdata,
    // Rebuild side
    input  logic  b_we,
    input  addr_t b_addr,
    input  data_t b_wdata
);

    localparam int DEPTH = 1 << ADDR_W;

    data_t mem [DEPTH];

    logic [ADDR_W-1:0] a_idx;
    logic [ADDR_W-1:0] b_idx;

    assign a_idx = a_addr[ADDR_W-1:0];
    assign b_idx = b_addr[ADDR_W-1:0];

    always_ff @(posedge CORE_CLK)
    begin
        if (a_we)
            mem[a_idx] <= a_wdata;
        if (b_we)
            mem[b_idx] <= b_wdata;
    end

    // Write-first on port A, so the scan right after a write beat sees new data
    always_ff @(posedge CORE_CLK)
    begin
        if (a_we)
            a_rdata <= a_wdata;
        else
            a_rdata <= mem[a_idx];
    end

    // Host writes only in lockstep, rebuild writes only outside it
    a_b_same_addr: assert property (@(posedge CORE_CLK) !(a_we && b_we && (a_idx == b_idx)));

endmodule

// ==== design/bcast_scanner.sv ====
`timescale 1ns/1ps

module bcast_scanner
    import lockstep_pkg::*;
#(
    parameter int ADDR_W = 9
)
(
    input  logic       CORE_CLK,
    input  logic       RST_n,
    input  module_id_t module_id,
    input  run_level_e run_level,
    input  logic       vote_good,
    input  logic       align_load,
    input  addr_t      align_addr,
    // Host write port
    input  logic       wr_valid,
    input  addr_t      wr_addr,
    input  data_t      wr_data,
    output logic       wr_ready,
    // Memory port A
    output logic       a_we,
    output addr_t      a_addr,
    output data_t      a_wdata,
    input  data_t      a_rdata,
    output bcast_t     bcast_out
);

    localparam logic [ADDR_W-1:0] STEP_ONE = {{(ADDR_W-1){1'b0}}, 1'b1};
    localparam logic [ADDR_W-1:0] STEP_TWO = {{(ADDR_W-2){1'b0}}, 2'b10};

    logic [ADDR_W-1:0] scan_cnt;
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] beat_addr;
    logic              scan_fresh;
    logic              wr_beat_vld;
    logic [ADDR_W-1:0] wr_beat_addr;
    data_t             wr_beat_data;
    logic              in_run;
    logic              wr_accept;

    assign in_run    = (run_level == RL_RUN);
    // A losing cycle takes no write, so no write beat lands in rebuild
    assign wr_ready  = in_run && vote_good && !wr_beat_vld;
    assign wr_accept = wr_valid && wr_ready;

    // --------------------------------------------------
    // Memory port A
    // --------------------------------------------------

    // Write beat borrows the port for one cycle
    assign rd_addr = wr_beat_vld ? wr_beat_addr : scan_cnt;
    assign a_we    = wr_beat_vld;
    assign a_addr  = addr_t'(rd_addr);
    assign a_wdata = wr_beat_data;

    always_ff @(posedge CORE_CLK)
    begin
        if (!RST_n)
        begin
            scan_cnt    <= '0;
            beat_addr   <= '0;
            scan_fresh  <= 1'b1;
            wr_beat_vld <= 1'b0;
        end
        else
        begin
            wr_beat_vld <= wr_accept;
            // Lines up with a_rdata on the next cycle
            beat_addr   <= rd_addr;
            scan_fresh  <= !wr_beat_vld;

            // Back off two so the address lost to the write comes round again
            if (wr_beat_vld)
                scan_cnt <= scan_cnt - STEP_TWO;
            else if (align_load)
                scan_cnt <= align_addr[ADDR_W-1:0] + STEP_TWO;
            else
                scan_cnt <= scan_cnt + STEP_ONE;
        end
    end

    always_ff @(posedge CORE_CLK)
    begin
        if (wr_accept)
        begin
            wr_beat_addr <= wr_addr[ADDR_W-1:0];
            wr_beat_data <= wr_data;
        end
    end

    // --------------------------------------------------
    // Broadcast beat
    // --------------------------------------------------

    always_comb
    begin
        if (!in_run)
        begin
            bcast_out.beat = BEAT_IDLE;
            bcast_out.addr = addr_t'(module_id);
            bcast_out.data = data_t'(module_id);
            bcast_out.sync = 1'b0;
        end
        else if (wr_beat_vld)
        begin
            bcast_out.beat = BEAT_WRITE;
            bcast_out.addr = addr_t'(wr_beat_addr);
            bcast_out.data = wr_beat_data;
            bcast_out.sync = 1'b0;
        end
        else
        begin
            bcast_out.beat = BEAT_SCAN;
            bcast_out.addr = addr_t'(beat_addr);
            bcast_out.data = a_rdata;
            // Sync marks the counter wrap, not the re-read of a written address
            bcast_out.sync = scan_fresh && (beat_addr == '0);
        end
        bcast_out.ok = in_run && vote_good;
    end

    no_write_beat_out_of_run: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        wr_beat_vld |-> in_run);

endmodule

// ==== design/lockstep_voter.sv ====
`timescale 1ns/1ps

module lockstep_voter
    import lockstep_pkg::*;
(
    input  bcast_t bcast_out,
    input  bcast_t nbr_in0,
    input  bcast_t nbr_in1,
    input  bcast_t nbr_in2,
    output logic   vote_good,
    output bcast_t nbr_sel
);

    localparam bcast_t NO_NBR = '{
        ok:   1'b0,
        beat: BEAT_IDLE,
        addr: '0,
        data: '0,
        sync: 1'b0
    };

    bcast_t     nbr [3];
    logic [2:0] agree;

    assign nbr[0] = nbr_in0;
    assign nbr[1] = nbr_in1;
    assign nbr[2] = nbr_in2;

    // --------------------------------------------------
    // Vote
    // --------------------------------------------------

    // ok and beat code stay out of the compare
    always_comb
    begin
        for (int i = 0; i < 3; i++)
        begin
            agree[i] = (bcast_out.addr == nbr[i].addr) &&
                       (bcast_out.data == nbr[i].data) &&
                       (bcast_out.sync == nbr[i].sync);
        end
    end

    // One agreeing neighbor is enough
    assign vote_good = |agree;

    // --------------------------------------------------
    // Neighbor selection
    // --------------------------------------------------

    // Neighbor 0 first, then 1, then 2
    always_comb
    begin
        if (nbr_in0.ok)
            nbr_sel = nbr_in0;
        else if (nbr_in1.ok)
            nbr_sel = nbr_in1;
        else if (nbr_in2.ok)
            nbr_sel = nbr_in2;
        else
            nbr_sel = NO_NBR;
    end

endmodule

// ==== design/rebuild_ctrl.sv ====
`timescale 1ns/1ps

module rebuild_ctrl
    import lockstep_pkg::*;
#(
    parameter int ADDR_W = 9
)
(
    input  logic       CORE_CLK,
    input  logic       RST_n,
    input  logic       vote_good,
    input  bcast_t     nbr_sel,
    output run_level_e run_level,
    output logic       align_load,
    output addr_t      align_addr,
    // Memory port B
    output logic       b_we,
    output addr_t      b_addr,
    output data_t      b_wdata
);

    localparam int WRAP_W = $clog2(REBUILD_PASSES + 1);
    localparam logic [WRAP_W-1:0] WRAP_ONE  = {{(WRAP_W-1){1'b0}}, 1'b1};
    localparam logic [WRAP_W-1:0] WRAP_DONE = WRAP_W'(REBUILD_PASSES);

    run_level_e            rl_nxt;
    logic [WRAP_W-1:0]     wrap_cnt;
    logic [SYNC_DELAY-1:0] sync_dly;
    logic                  nbr_live;
    logic                  nbr_scan;
    logic                  nbr_wrap;
    logic                  nbr_was_write;
    logic                  copying;

    assign nbr_live = nbr_sel.ok && (nbr_sel.beat != BEAT_IDLE);
    assign nbr_scan = nbr_sel.ok && (nbr_sel.beat == BEAT_SCAN);
    assign nbr_wrap = nbr_scan && (nbr_sel.addr[ADDR_W-1:0] == '0);
    assign copying  = (run_level == RL_REBUILD) || (run_level == RL_ALIGN);

    // --------------------------------------------------
    // Rebuild writes and address alignment
    // --------------------------------------------------

    assign b_we    = copying && nbr_live;
    assign b_addr  = addr_t'(nbr_sel.addr[ADDR_W-1:0]);
    assign b_wdata = nbr_sel.data;

    // The scan right after a write beat repeats the written address,
    // so it says nothing about the neighbor's counter
    assign align_load = (run_level == RL_ALIGN) && nbr_scan && !nbr_was_write;
    assign align_addr = nbr_sel.addr;

    // --------------------------------------------------
    // Run level FSM
    // --------------------------------------------------

    always_comb
    begin
        rl_nxt = run_level;
        case (run_level)
            RL_RUN:
                if (!vote_good)
                    rl_nxt = RL_REBUILD;
            RL_REBUILD:
                if (wrap_cnt == WRAP_DONE)
                    rl_nxt = RL_ALIGN;
            RL_ALIGN:
                if (nbr_sel.ok && nbr_sel.sync)
                    rl_nxt = RL_REJOIN;
            RL_REJOIN:
                // Own scan pipeline has refilled by now
                if (sync_dly[SYNC_DELAY-1])
                    rl_nxt = RL_RUN;
            default:
                rl_nxt = RL_RUN;
        endcase
    end

    always_ff @(posedge CORE_CLK)
    begin
        if (!RST_n)
        begin
            run_level     <= RL_RUN;
            wrap_cnt      <= '0;
            sync_dly      <= '0;
            nbr_was_write <= 1'b0;
        end
        else
        begin
            run_level     <= rl_nxt;
            sync_dly      <= {sync_dly[SYNC_DELAY-2:0], nbr_sel.sync};
            nbr_was_write <= nbr_sel.ok && (nbr_sel.beat == BEAT_WRITE);

            // Count neighbor scan wraps while copying
            if (run_level == RL_RUN)
                wrap_cnt <= '0;
            else if ((run_level == RL_REBUILD) && nbr_wrap && (wrap_cnt != WRAP_DONE))
                wrap_cnt <= wrap_cnt + WRAP_ONE;
        end
    end

    run_exits_to_rebuild: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        (run_level == RL_RUN) |=> (run_level inside {RL_RUN, RL_REBUILD}));

endmodule

// ==== design/lockstep_module.sv ====
`timescale 1ns/1ps

module lockstep_module
    import lockstep_pkg::*;
#(
    parameter int ADDR_W = 9
)
(
    input  logic       CORE_CLK,
    input  logic       RST_n,
    input  module_id_t module_id,
    // Host write port
    input  logic       wr_valid,
    input  addr_t      wr_addr,
    input  data_t      wr_data,
    output logic       wr_ready,
    // Broadcast bus
    output bcast_t     bcast_out,
    input  bcast_t     nbr_in0,
    input  bcast_t     nbr_in1,
    input  bcast_t     nbr_in2
);

    run_level_e run_level;
    logic       vote_good;
    bcast_t     nbr_sel;
    logic       align_load;
    addr_t      align_addr;

    logic       a_we;
    addr_t      a_addr;
    data_t      a_wdata;
    data_t      a_rdata;
    logic       b_we;
    addr_t      b_addr;
    data_t      b_wdata;

    // --------------------------------------------------
    // State memory
    // --------------------------------------------------

    state_ram #(
        .ADDR_W (ADDR_W)
    ) u_state_ram (
        .CORE_CLK (CORE_CLK),
        .a_we     (a_we),
        .a_addr   (a_addr),
        .a_wdata  (a_wdata),
        .a_rdata  (a_rdata),
        .b_we     (b_we),
        .b_addr   (b_addr),
        .b_wdata  (b_wdata)
    );

    // --------------------------------------------------
    // Broadcast and vote
    // --------------------------------------------------

    bcast_scanner #(
        .ADDR_W (ADDR_W)
    ) u_bcast_scanner (
        .CORE_CLK   (CORE_CLK),
        .RST_n      (RST_n),
        .module_id  (module_id),
        .run_level  (run_level),
        .vote_good  (vote_good),
        .align_load (align_load),
        .align_addr (align_addr),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_ready   (wr_ready),
        .a_we       (a_we),
        .a_addr     (a_addr),
        .a_wdata    (a_wdata),
        .a_rdata    (a_rdata),
        .bcast_out  (bcast_out)
    );

    lockstep_voter u_lockstep_voter (
        .bcast_out (bcast_out),
        .nbr_in0   (nbr_in0),
        .nbr_in1   (nbr_in1),
        .nbr_in2   (nbr_in2),
        .vote_good (vote_good),
        .nbr_sel   (nbr_sel)
    );

    // Rebuild from the selected neighbor
    rebuild_ctrl #(
        .ADDR_W (ADDR_W)
    ) u_rebuild_ctrl (
        .CORE_CLK   (CORE_CLK),
        .RST_n      (RST_n),
        .vote_good  (vote_good),
        .nbr_sel    (nbr_sel),
        .run_level  (run_level),
        .align_load (align_load),
        .align_addr (align_addr),
        .b_we       (b_we),
        .b_addr     (b_addr),
        .b_wdata    (b_wdata)
    );

endmodule

// ==== verification/lockstep_tb.sv ====
`timescale 1ns/1ps

module lockstep_tb
    import lockstep_pkg::*;
();

    localparam int ADDR_W        = 6;
    localparam int WRAP          = 1 << ADDR_W;
    localparam int CLK_PERIOD    = 4;
    localparam int NUM_WRITES    = 12;
    // Four scan wraps plus margin
    localparam int REBUILD_BOUND = 4 * WRAP + 32;
    localparam int RUN_CYCLES    = 4 + NUM_WRITES * 4 + 2 * WRAP + 24
                                   + 2 * (REBUILD_BOUND + 2 * WRAP) + REBUILD_BOUND
                                   + 2 * WRAP;
    localparam int WATCHDOG_NS   = CLK_PERIOD * (RUN_CYCLES + 64);

    logic              CORE_CLK;
    logic              RST_n;
    module_id_t        module_id;
    logic              wr_valid;
    addr_t             wr_addr;
    data_t             wr_data;
    logic              wr_ready;
    bcast_t            bcast_out;
    bcast_t            nbr [3];

    // Neighbor model controls
    logic              mirror;
    logic [2:0]        off_mask;
    logic [2:0]        bad_mask;
    logic [ADDR_W-1:0] gold_cnt;
    data_t             gold_mem [WRAP];
    data_t             shadow_mem [WRAP];
    logic              shadow_vld [WRAP];

    logic              chk_ok;
    logic              gold_chk;
    logic              expect_drop;
    logic              expect_idle;
    int                err_cnt;
    int                err_mark;
    int                test_cnt;
    int                test_fail;
    logic [31:0]       lfsr;

    logic [ADDR_W-1:0] beat_idx;
    logic              exp_vld;
    data_t             exp_data;

    lockstep_module #(
        .ADDR_W (ADDR_W)
    ) dut0 (
        .CORE_CLK  (CORE_CLK),
        .RST_n     (RST_n),
        .module_id (module_id),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .bcast_out (bcast_out),
        .nbr_in0   (nbr[0]),
        .nbr_in1   (nbr[1]),
        .nbr_in2   (nbr[2])
    );

    initial
    begin
        CORE_CLK = 1'b0;
        forever
            #(CLK_PERIOD / 2) CORE_CLK = ~CORE_CLK;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    // --------------------------------------------------
    // Expected scan data and checks
    // --------------------------------------------------

    assign beat_idx = bcast_out.addr[ADDR_W-1:0];

    always_comb
    begin
        if (mirror)
        begin
            exp_vld  = shadow_vld[beat_idx];
            exp_data = shadow_mem[beat_idx];
        end
        else
        begin
            exp_vld  = gold_chk;
            exp_data = gold_mem[beat_idx];
        end
    end

    function automatic void log_mismatch(input string msg);
        err_cnt++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endfunction

    write_beat_chk: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        $past(wr_valid && wr_ready) |->
            (bcast_out.beat == BEAT_WRITE) && (bcast_out.addr == $past(wr_addr)) &&
            (bcast_out.data == $past(wr_data)) && !wr_ready)
        else log_mismatch("write beat does not carry the accepted write");

    scan_beat_chk: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        (chk_ok && !$past(wr_valid && wr_ready)) |-> (bcast_out.beat == BEAT_SCAN))
        else log_mismatch("beat in lockstep is neither a write beat nor a scan beat");

    scan_data_chk: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        ((bcast_out.beat == BEAT_SCAN) && exp_vld) |-> (bcast_out.data == exp_data))
        else log_mismatch("scan beat data differs from the expected memory");

    gold_scan_chk: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        gold_chk |-> ((bcast_out.addr == nbr[0].addr) && (bcast_out.sync == nbr[0].sync)))
        else log_mismatch("scan address or sync differs from the golden scan");

    run_ok_chk: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        chk_ok |-> (bcast_out.ok && (dut0.run_level == RL_RUN)))
        else log_mismatch("module left lockstep");

    drop_chk: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        expect_drop |-> !bcast_out.ok)
        else log_mismatch("ok stayed high with all neighbors disagreeing");

    idle_chk: assert property (@(posedge CORE_CLK) disable iff (!RST_n)
        expect_idle |-> ((bcast_out.beat == BEAT_IDLE) && !bcast_out.sync && !wr_ready &&
                         (bcast_out.addr == addr_t'(module_id)) &&
                         (bcast_out.data == data_t'(module_id))))
        else log_mismatch("beat out of lockstep is not an idle beat");

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Mirror copies the module, golden mode scans the golden memory
    task automatic drive_nbrs();
        bcast_t base;
        if (mirror)
            base = bcast_out;
        else
        begin
            base.beat = BEAT_SCAN;
            base.addr = addr_t'(gold_cnt);
            base.data = gold_mem[gold_cnt];
            base.sync = (gold_cnt == '0);
        end
        base.ok  = 1'b1;
        gold_cnt = gold_cnt + 1'b1;
        for (int i = 0; i < 3; i++)
        begin
            nbr[i] = base;
            if (bad_mask[i])
                nbr[i].data = ~base.data;
            if (off_mask[i])
                nbr[i].ok = 1'b0;
        end
    endtask

    task automatic next_cycle();
        @(negedge CORE_CLK);
        drive_nbrs();
    endtask

    task automatic host_write(input addr_t a, input data_t d);
        next_cycle();
        wr_valid = 1'b1;
        wr_addr  = a;
        wr_data  = d;
        #1;
        while (!wr_ready)
        begin
            next_cycle();
            #1;
        end
        next_cycle();
        wr_valid = 1'b0;
        shadow_mem[a[ADDR_W-1:0]] = d;
        shadow_vld[a[ADDR_W-1:0]] = 1'b1;
    endtask

    task automatic wait_for_ok(input logic level, input string what);
        int n;
        n = 0;
        next_cycle();
        #1;
        while ((bcast_out.ok !== level) && (n < REBUILD_BOUND))
        begin
            next_cycle();
            #1;
            n++;
        end
        if (bcast_out.ok !== level)
        begin
            err_cnt++;
            $display("ERROR at %0t: the module did not %s within %0d cycles",
                     $time, what, REBUILD_BOUND);
        end
    endtask

    task automatic fill_golden();
        for (int i = 0; i < WRAP; i++)
            gold_mem[i[ADDR_W-1:0]] = data_t'(rand_bits(8));
    endtask

    task automatic end_test(input int num, input string name);
        test_cnt++;
        if (err_cnt != err_mark)
            test_fail++;
        $display("test %0d %s: %s", num, name, (err_cnt == err_mark) ? "ok" : "FAILED");
        err_mark = err_cnt;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial
    begin
        lfsr        = 32'hc97b_1e33;
        RST_n       = 1'b0;
        module_id   = 2'd1;
        wr_valid    = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        mirror      = 1'b1;
        off_mask    = '0;
        bad_mask    = '0;
        gold_cnt    = '0;
        chk_ok      = 1'b0;
        gold_chk    = 1'b0;
        expect_drop = 1'b0;
        expect_idle = 1'b0;
        err_cnt     = 0;
        err_mark    = 0;
        test_cnt    = 0;
        test_fail   = 0;
        for (int i = 0; i < 3; i++)
            nbr[i] = '0;
        for (int i = 0; i < WRAP; i++)
        begin
            shadow_vld[i[ADDR_W-1:0]] = 1'b0;
            shadow_mem[i[ADDR_W-1:0]] = '0;
            gold_mem[i[ADDR_W-1:0]]   = '0;
        end
        next_cycle();
        next_cycle();
        RST_n = 1'b1;

        chk_ok = 1'b1;
        for (int i = 0; i < NUM_WRITES; i++)
            host_write(addr_t'(rand_bits(ADDR_W)), data_t'(rand_bits(8)));
        end_test(1, "host write beat");

        repeat (2 * WRAP) next_cycle();
        end_test(2, "scan agreement");

        // One cycle with every neighbor disagreeing
        chk_ok   = 1'b0;
        bad_mask = 3'b111;
        next_cycle();
        expect_drop = 1'b1;
        bad_mask    = 3'b000;
        next_cycle();
        expect_drop = 1'b0;
        expect_idle = 1'b1;
        repeat (20) next_cycle();
        expect_idle = 1'b0;
        end_test(3, "vote loss");

        mirror = 1'b0;
        fill_golden();
        wait_for_ok(1'b1, "rejoin after rebuilding");
        gold_chk = 1'b1;
        chk_ok   = 1'b1;
        repeat (2 * WRAP) next_cycle();
        end_test(4, "rebuild and rejoin");

        // Neighbor 0 off, neighbor 2 corrupt, only neighbor 1 is golden
        gold_chk = 1'b0;
        chk_ok   = 1'b0;
        off_mask = 3'b001;
        bad_mask = 3'b101;
        fill_golden();
        wait_for_ok(1'b0, "drop out after the golden memory changed");
        wait_for_ok(1'b1, "rejoin from neighbor 1");
        gold_chk = 1'b1;
        chk_ok   = 1'b1;
        repeat (2 * WRAP) next_cycle();
        end_test(5, "neighbor priority");

        off_mask = 3'b000;
        bad_mask = 3'b110;
        repeat (2 * WRAP) next_cycle();
        chk_ok = 1'b0;
        end_test(6, "majority of one");

        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== lockstep.f ====
design/lockstep_pkg.sv
design/state_ram.sv
design/bcast_scanner.sv
design/lockstep_voter.sv
design/rebuild_ctrl.sv
design/lockstep_module.sv
verification/lockstep_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the lockstep testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module lockstep_tb \
    --Mdir obj_dir -o lockstep_sim -f lockstep.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lockstep_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1
